// ==== design/alloc_tag_queues.sv ====
`timescale 1ns/1ps
`default_nettype none

module alloc_tag_queues (
    input  logic                                dma_clk,
    input  logic                                rst_n,

    // granted request
    input  logic                                alloc_grant,
    input  logic [np_tag_pkg::TAG_NUM_LOG-1:0]  alloc_tag,
    input  logic [np_tag_pkg::CHNL_W-1:0]       tag_rreq_chnl,
    input  logic [np_tag_pkg::DW_LEN_WIDTH-1:0] tag_rreq_sz,
    input  logic                                tag_rreq_last,
    input  logic [np_tag_pkg::TAG_MISC-1:0]     tag_rreq_misc,

    // release side
    input  logic [np_tag_pkg::RD_CHNL_NUM-1:0]  rel_pop,
    output wire  [np_tag_pkg::RD_CHNL_NUM-1:0]  q_empty,
    output wire  [np_tag_pkg::RD_CHNL_NUM*np_tag_pkg::ENTRY_W-1:0] q_head
);

    logic [np_tag_pkg::ENTRY_W-1:0]    alloc_entry;
    wire  [np_tag_pkg::RD_CHNL_NUM-1:0] q_push;

    // ************************************************************
    // record packing
    // ************************************************************
    assign alloc_entry = {alloc_tag, tag_rreq_sz, tag_rreq_last, tag_rreq_misc};

    // ************************************************************
    // one in-order queue per read channel
    // ************************************************************
    for (genvar i = 0; i < np_tag_pkg::RD_CHNL_NUM; i++) begin : g_chnl

        assign q_push[i] = alloc_grant &&
                           (tag_rreq_chnl == np_tag_pkg::CHNL_W'(i));

        tag_sync_fifo #(
            .DSIZE (np_tag_pkg::ENTRY_W),
            .ASIZE (np_tag_pkg::TAG_NUM_LOG)
        ) i_chnl_fifo (
            .dma_clk (dma_clk),
            .rst_n   (rst_n),
            .wen     (q_push[i]),
            .din     (alloc_entry),
            .full    (),
            .ren     (rel_pop[i]),  // valid and ready from the arbiter
            .dout    (q_head[i*np_tag_pkg::ENTRY_W +: np_tag_pkg::ENTRY_W]),
            .empty   (q_empty[i])
        );

    end

endmodule

`default_nettype wire

// ==== design/free_tag_pool.sv ====
`timescale 1ns/1ps
`default_nettype none

module free_tag_pool (
    input  logic                               dma_clk,
    input  logic                               rst_n,
    output logic                               init_done,  // pool holds every tag

    // allocation handshake
    input  logic                               tag_rreq_ready,
    output logic                               tag_rreq_valid,
    output logic [np_tag_pkg::TAG_NUM_LOG-1:0] tag_rreq_tag,

    // grant to the channel queues
    output logic                               alloc_grant,
    output logic [np_tag_pkg::TAG_NUM_LOG-1:0] alloc_tag,

    // released tags from the arbiter
    input  logic                               ret_valid,
    input  logic [np_tag_pkg::TAG_NUM_LOG-1:0] ret_tag
);

    logic [np_tag_pkg::TAG_NUM_LOG-1:0] init_cnt;
    logic                               pool_wen;
    logic [np_tag_pkg::TAG_NUM_LOG-1:0] pool_din;
    logic [np_tag_pkg::TAG_NUM_LOG-1:0] pool_dout;
    logic                               pool_empty;

    // ************************************************************
    // init fill, one tag value per cycle
    // ************************************************************
    always_ff @(posedge dma_clk or negedge rst_n) begin
        if (!rst_n) begin
            init_cnt <= '0;
        end else if (init_cnt != np_tag_pkg::TAG_LAST) begin
            init_cnt <= init_cnt + 1'b1;
        end
    end

    always_ff @(posedge dma_clk or negedge rst_n) begin
        if (!rst_n) begin
            init_done <= 1'b0;
        end else if (init_cnt == np_tag_pkg::TAG_LAST) begin
            init_done <= 1'b1;  // last fill write happens on this edge
        end
    end

    // fill values first and returned tags afterwards
    assign pool_wen = init_done ? ret_valid : 1'b1;
    assign pool_din = init_done ? ret_tag : init_cnt;

    tag_sync_fifo #(
        .DSIZE (np_tag_pkg::TAG_NUM_LOG),
        .ASIZE (np_tag_pkg::TAG_NUM_LOG)
    ) i_pool_fifo (
        .dma_clk (dma_clk),
        .rst_n   (rst_n),
        .wen     (pool_wen),
        .din     (pool_din),
        .full    (),
        .ren     (alloc_grant),
        .dout    (pool_dout),
        .empty   (pool_empty)
    );

    // ************************************************************
    // tag offer
    // ************************************************************
    assign tag_rreq_valid = init_done & ~pool_empty;  // no offer during the fill
    assign tag_rreq_tag   = pool_dout;

    assign alloc_grant = tag_rreq_valid & tag_rreq_ready;
    assign alloc_tag   = pool_dout;

    // no tag can be outstanding before the pool has offered one
    a_no_early_ret: assert property (
        @(posedge dma_clk) disable iff (!rst_n) ret_valid |-> init_done
    ) else $error("free_tag_pool: tag returned before init_done");

endmodule

`default_nettype wire

// ==== design/np_tag_mgmt.sv ====
`timescale 1ns/1ps
`default_nettype none

module np_tag_mgmt (
    input  logic                                dma_clk,
    input  logic                                rst_n,
    output logic                                init_done,

    // ************************************************************
    // tag request
    // ************************************************************
    input  logic                                tag_rreq_ready,
    input  logic [np_tag_pkg::CHNL_W-1:0]       tag_rreq_chnl,   // requesting channel
    input  logic [np_tag_pkg::DW_LEN_WIDTH-1:0] tag_rreq_sz,
    input  logic                                tag_rreq_last,   // last sub-req of a read
    input  logic [np_tag_pkg::TAG_MISC-1:0]     tag_rreq_misc,
    output logic                                tag_rreq_valid,
    output logic [np_tag_pkg::TAG_NUM_LOG-1:0]  tag_rreq_tag,

    // ************************************************************
    // tag release, channel i in slice i
    // ************************************************************
    input  logic [np_tag_pkg::RD_CHNL_NUM-1:0]                        tag_rrsp_ready,
    output logic [np_tag_pkg::RD_CHNL_NUM-1:0]                        tag_rrsp_valid,
    output wire  [np_tag_pkg::RD_CHNL_NUM*np_tag_pkg::TAG_NUM_LOG-1:0]  tag_rrsp_tag,
    output wire  [np_tag_pkg::RD_CHNL_NUM*np_tag_pkg::DW_LEN_WIDTH-1:0] tag_rrsp_sz,
    output wire  [np_tag_pkg::RD_CHNL_NUM-1:0]                        tag_rrsp_last,
    output wire  [np_tag_pkg::RD_CHNL_NUM*np_tag_pkg::TAG_MISC-1:0]   tag_rrsp_misc
);

    logic                                          alloc_grant;
    logic [np_tag_pkg::TAG_NUM_LOG-1:0]            alloc_tag;
    logic [np_tag_pkg::RD_CHNL_NUM-1:0]            rel_pop;
    logic                                          ret_valid;
    logic [np_tag_pkg::TAG_NUM_LOG-1:0]            ret_tag;
    wire  [np_tag_pkg::RD_CHNL_NUM-1:0]            q_empty;
    wire  [np_tag_pkg::RD_CHNL_NUM*np_tag_pkg::ENTRY_W-1:0] q_head;

    free_tag_pool i_pool (
        .dma_clk        (dma_clk),
        .rst_n          (rst_n),
        .init_done      (init_done),
        .tag_rreq_ready (tag_rreq_ready),
        .tag_rreq_valid (tag_rreq_valid),
        .tag_rreq_tag   (tag_rreq_tag),
        .alloc_grant    (alloc_grant),
        .alloc_tag      (alloc_tag),
        .ret_valid      (ret_valid),
        .ret_tag        (ret_tag)
    );

    alloc_tag_queues i_queues (
        .dma_clk       (dma_clk),
        .rst_n         (rst_n),
        .alloc_grant   (alloc_grant),
        .alloc_tag     (alloc_tag),
        .tag_rreq_chnl (tag_rreq_chnl),
        .tag_rreq_sz   (tag_rreq_sz),
        .tag_rreq_last (tag_rreq_last),
        .tag_rreq_misc (tag_rreq_misc),
        .rel_pop       (rel_pop),
        .q_empty       (q_empty),
        .q_head        (q_head)
    );

    tag_release_arb i_arb (
        .q_empty        (q_empty),
        .q_head         (q_head),
        .tag_rrsp_ready (tag_rrsp_ready),
        .tag_rrsp_valid (tag_rrsp_valid),
        .tag_rrsp_tag   (tag_rrsp_tag),
        .tag_rrsp_sz    (tag_rrsp_sz),
        .tag_rrsp_last  (tag_rrsp_last),
        .tag_rrsp_misc  (tag_rrsp_misc),
        .rel_pop        (rel_pop),
        .ret_valid      (ret_valid),
        .ret_tag        (ret_tag)
    );

endmodule

`default_nettype wire

// ==== design/np_tag_pkg.sv ====
`default_nettype none

package np_tag_pkg;

    // ************************************************************
    // tag pool and request field sizes
    // ************************************************************
    localparam int TAG_NUM      = 16;
    localparam int TAG_NUM_LOG  = 4;   // tag width
    localparam int DW_LEN_WIDTH = 10;  // request size in dwords
    localparam int TAG_MISC     = 8;   // addr and dw empty info
    localparam int RD_CHNL_NUM  = 4;
    localparam int CHNL_W       = 2;   // channel number width

    // ************************************************************
    // queue entry layout, msb first: tag, sz, last, misc
    // ************************************************************
    localparam int ENTRY_W  = TAG_NUM_LOG + DW_LEN_WIDTH + 1 + TAG_MISC;
    localparam int LAST_BIT = TAG_MISC;              // misc sits at bit 0
    localparam int SZ_LSB   = LAST_BIT + 1;
    localparam int TAG_LSB  = SZ_LSB + DW_LEN_WIDTH;

    // final tag value written by the init fill
    localparam logic [TAG_NUM_LOG-1:0] TAG_LAST = TAG_NUM_LOG'(TAG_NUM - 1);

endpackage

`default_nettype wire

// ==== design/tag_release_arb.sv ====
`timescale 1ns/1ps
`default_nettype none

module tag_release_arb (
    input  logic [np_tag_pkg::RD_CHNL_NUM-1:0]                      q_empty,
    input  logic [np_tag_pkg::RD_CHNL_NUM*np_tag_pkg::ENTRY_W-1:0]  q_head,

    // per-channel release handshake
    input  logic [np_tag_pkg::RD_CHNL_NUM-1:0]                      tag_rrsp_ready,
    output logic [np_tag_pkg::RD_CHNL_NUM-1:0]                      tag_rrsp_valid,
    output wire  [np_tag_pkg::RD_CHNL_NUM*np_tag_pkg::TAG_NUM_LOG-1:0]  tag_rrsp_tag,
    output wire  [np_tag_pkg::RD_CHNL_NUM*np_tag_pkg::DW_LEN_WIDTH-1:0] tag_rrsp_sz,
    output wire  [np_tag_pkg::RD_CHNL_NUM-1:0]                      tag_rrsp_last,
    output wire  [np_tag_pkg::RD_CHNL_NUM*np_tag_pkg::TAG_MISC-1:0] tag_rrsp_misc,

    // queue pop and pool return
    output logic [np_tag_pkg::RD_CHNL_NUM-1:0]                      rel_pop,
    output logic                                                    ret_valid,
    output logic [np_tag_pkg::TAG_NUM_LOG-1:0]                      ret_tag
);

    logic [np_tag_pkg::RD_CHNL_NUM-1:0] not_empty;

    // ************************************************************
    // lowest non-empty channel presents
    // ************************************************************
    assign not_empty      = ~q_empty;
    assign tag_rrsp_valid = not_empty & (~not_empty + 1'b1);  // isolate lowest set bit

    // every head is unpacked and valid tells which one counts
    for (genvar i = 0; i < np_tag_pkg::RD_CHNL_NUM; i++) begin : g_unpack
        wire [np_tag_pkg::ENTRY_W-1:0] head;

        assign head = q_head[i*np_tag_pkg::ENTRY_W +: np_tag_pkg::ENTRY_W];

        assign tag_rrsp_tag[i*np_tag_pkg::TAG_NUM_LOG +: np_tag_pkg::TAG_NUM_LOG] =
            head[np_tag_pkg::TAG_LSB +: np_tag_pkg::TAG_NUM_LOG];
        assign tag_rrsp_sz[i*np_tag_pkg::DW_LEN_WIDTH +: np_tag_pkg::DW_LEN_WIDTH] =
            head[np_tag_pkg::SZ_LSB +: np_tag_pkg::DW_LEN_WIDTH];
        assign tag_rrsp_last[i] = head[np_tag_pkg::LAST_BIT];
        assign tag_rrsp_misc[i*np_tag_pkg::TAG_MISC +: np_tag_pkg::TAG_MISC] =
            head[np_tag_pkg::TAG_MISC-1:0];
    end

    // ************************************************************
    // pop and tag return at most once per cycle
    // ************************************************************
    assign rel_pop   = tag_rrsp_valid & tag_rrsp_ready;
    assign ret_valid = |rel_pop;

    always_comb begin
        ret_tag = '0;
        for (int i = 0; i < np_tag_pkg::RD_CHNL_NUM; i++) begin
            if (rel_pop[i]) begin
                ret_tag = tag_rrsp_tag[i*np_tag_pkg::TAG_NUM_LOG +: np_tag_pkg::TAG_NUM_LOG];
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/tag_sync_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module tag_sync_fifo #(
    parameter int DSIZE = 4,
    parameter int ASIZE = 4
) (
    input  logic             dma_clk,
    input  logic             rst_n,

    input  logic             wen,
    input  logic [DSIZE-1:0] din,
    output logic             full,

    input  logic             ren,
    output logic [DSIZE-1:0] dout,
    output logic             empty
);

    logic [DSIZE-1:0] mem [2**ASIZE];
    logic [ASIZE:0]   wr_ptr;  // msb is the wrap bit
    logic [ASIZE:0]   rd_ptr;

    // ************************************************************
    // pointers
    // ************************************************************
    always_ff @(posedge dma_clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wen) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (ren) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // storage
    always_ff @(posedge dma_clk) begin
        if (wen) begin
            mem[wr_ptr[ASIZE-1:0]] <= din;
        end
    end

    // ************************************************************
    // status and show-ahead read
    // ************************************************************
    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[ASIZE] != rd_ptr[ASIZE]) &&
                   (wr_ptr[ASIZE-1:0] == rd_ptr[ASIZE-1:0]);  // same slot, one lap apart

    assign dout = mem[rd_ptr[ASIZE-1:0]];  // head visible without a read

    // the writer and the reader live in other modules
    a_no_overflow: assert property (
        @(posedge dma_clk) disable iff (!rst_n) wen |-> !full
    ) else $error("tag_sync_fifo: write while full");

    a_no_underflow: assert property (
        @(posedge dma_clk) disable iff (!rst_n) ren |-> !empty
    ) else $error("tag_sync_fifo: read while empty");

endmodule

`default_nettype wire

// ==== sim.f ====
design/np_tag_pkg.sv
design/tag_sync_fifo.sv
design/free_tag_pool.sv
design/alloc_tag_queues.sv
design/tag_release_arb.sv
design/np_tag_mgmt.sv
tests/tb_np_tag_mgmt.sv

// ==== tests/tb_np_tag_mgmt.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_np_tag_mgmt;

    logic                                                   dma_clk;
    logic                                                   rst_n;
    logic                                                   init_done;
    logic                                                   tag_rreq_ready;
    logic [np_tag_pkg::CHNL_W-1:0]                          tag_rreq_chnl;
    logic [np_tag_pkg::DW_LEN_WIDTH-1:0]                    tag_rreq_sz;
    logic                                                   tag_rreq_last;
    logic [np_tag_pkg::TAG_MISC-1:0]                        tag_rreq_misc;
    logic                                                   tag_rreq_valid;
    logic [np_tag_pkg::TAG_NUM_LOG-1:0]                     tag_rreq_tag;
    logic [np_tag_pkg::RD_CHNL_NUM-1:0]                     tag_rrsp_ready;
    logic [np_tag_pkg::RD_CHNL_NUM-1:0]                     tag_rrsp_valid;
    wire  [np_tag_pkg::RD_CHNL_NUM*np_tag_pkg::TAG_NUM_LOG-1:0]  tag_rrsp_tag;
    wire  [np_tag_pkg::RD_CHNL_NUM*np_tag_pkg::DW_LEN_WIDTH-1:0] tag_rrsp_sz;
    wire  [np_tag_pkg::RD_CHNL_NUM-1:0]                     tag_rrsp_last;
    wire  [np_tag_pkg::RD_CHNL_NUM*np_tag_pkg::TAG_MISC-1:0] tag_rrsp_misc;

    logic [27:0] req_table [24];  // hex groups c_l_sss_mm hold chnl, last, sz and misc
    logic [np_tag_pkg::TAG_NUM_LOG-1:0] free_model [$];  // pool order
    logic [24:0] outstanding [$];  // {chnl, tag, sz, last, misc} in grant order

    np_tag_mgmt i_dut (.*);

    initial begin
        dma_clk = 1'b0;
        forever #4 dma_clk = ~dma_clk;
    end

    // ************************************************************
    // error reporting
    // ************************************************************
    task automatic report_mismatch(input string name, input logic [31:0] exp_val,
                                   input logic [31:0] act_val);
        $display("FAILED time=%0t %s expected=%0h actual=%0h", $time, name, exp_val, act_val);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic report_timeout(input string what);
        $display("timeout at %0t: %s", $time, what);
        $display("Test failed");
        $fatal(1);
    endtask

    // ************************************************************
    // reference model helpers
    // ************************************************************
    function automatic int lowest_busy_chnl();
        int low;
        low = -1;
        foreach (outstanding[k]) begin
            if (low < 0 || int'(outstanding[k][24:23]) < low) low = outstanding[k][24:23];
        end
        return low;
    endfunction

    function automatic int oldest_in_chnl(input int ch);
        for (int k = 0; k < outstanding.size(); k++) begin
            if (int'(outstanding[k][24:23]) == ch) return k;
        end
        return -1;
    endfunction

    // priority and pool state on every cycle
    always @(negedge dma_clk) begin
        logic [np_tag_pkg::RD_CHNL_NUM-1:0] exp_valid;
        int                                 low;
        if (rst_n) begin
            low       = lowest_busy_chnl();
            exp_valid = '0;
            if (low >= 0) exp_valid[low] = 1'b1;
            assert (tag_rrsp_valid == exp_valid)
                else report_mismatch("tag_rrsp_valid", exp_valid, tag_rrsp_valid);
            assert (tag_rreq_valid == (init_done && free_model.size() != 0))
                else report_mismatch("tag_rreq_valid", init_done && free_model.size() != 0,
                                     tag_rreq_valid);
        end
    end

    task automatic check_record(input int ch, input logic [24:0] rec);
        assert (tag_rrsp_tag[ch*np_tag_pkg::TAG_NUM_LOG +: np_tag_pkg::TAG_NUM_LOG] == rec[22:19])
            else report_mismatch("tag_rrsp_tag", rec[22:19],
                tag_rrsp_tag[ch*np_tag_pkg::TAG_NUM_LOG +: np_tag_pkg::TAG_NUM_LOG]);
        assert (tag_rrsp_sz[ch*np_tag_pkg::DW_LEN_WIDTH +: np_tag_pkg::DW_LEN_WIDTH] == rec[18:9])
            else report_mismatch("tag_rrsp_sz", rec[18:9],
                tag_rrsp_sz[ch*np_tag_pkg::DW_LEN_WIDTH +: np_tag_pkg::DW_LEN_WIDTH]);
        assert (tag_rrsp_last[ch] == rec[8])
            else report_mismatch("tag_rrsp_last", rec[8], tag_rrsp_last[ch]);
        assert (tag_rrsp_misc[ch*np_tag_pkg::TAG_MISC +: np_tag_pkg::TAG_MISC] == rec[7:0])
            else report_mismatch("tag_rrsp_misc", rec[7:0],
                tag_rrsp_misc[ch*np_tag_pkg::TAG_MISC +: np_tag_pkg::TAG_MISC]);
    endtask

    // ************************************************************
    // request and release sequences
    // ************************************************************
    task automatic alloc_row(input int r);
        logic [27:0]                        row;
        logic [np_tag_pkg::TAG_NUM_LOG-1:0] exp_tag;
        int                                 waited;
        row = req_table[r];
        @(posedge dma_clk);
        tag_rreq_ready <= 1'b1;
        tag_rreq_chnl  <= row[25:24];
        tag_rreq_last  <= row[20];
        tag_rreq_sz    <= row[17:8];
        tag_rreq_misc  <= row[7:0];
        waited = 0;
        @(negedge dma_clk);
        while (!tag_rreq_valid) begin
            waited++;
            if (waited > 40) report_timeout("no tag offered for a pending request");
            @(negedge dma_clk);
        end
        exp_tag = free_model[0];
        assert (tag_rreq_tag == exp_tag)
            else report_mismatch("tag_rreq_tag", exp_tag, tag_rreq_tag);
        @(posedge dma_clk);  // grant edge
        tag_rreq_ready <= 1'b0;
        void'(free_model.pop_front());
        outstanding.push_back({row[25:24], exp_tag, row[17:8], row[20], row[7:0]});
    endtask

    task automatic release_oldest();
        int                                 ch;
        int                                 idx;
        int                                 stall;
        int                                 waited;
        logic [24:0]                        exp_rec;
        logic [np_tag_pkg::RD_CHNL_NUM-1:0] ready_mask;
        ch         = lowest_busy_chnl();
        idx        = oldest_in_chnl(ch);
        exp_rec    = outstanding[idx];
        stall      = $urandom_range(0, 3);
        waited     = 0;
        ready_mask = '0;
        ready_mask[ch] = 1'b1;
        @(negedge dma_clk);
        while (!tag_rrsp_valid[ch]) begin
            waited++;
            if (waited > 40) report_timeout("channel never presented its record");
            @(negedge dma_clk);
        end
        check_record(ch, exp_rec);
        repeat (stall) begin
            @(negedge dma_clk);
            check_record(ch, exp_rec);  // held under back-pressure
        end
        @(posedge dma_clk);
        tag_rrsp_ready <= ready_mask;
        @(negedge dma_clk);
        check_record(ch, exp_rec);
        @(posedge dma_clk);  // pop and return edge
        tag_rrsp_ready <= '0;
        outstanding.delete(idx);
        free_model.push_back(exp_rec[22:19]);
    endtask

    initial begin
        int waited;
        void'($urandom(4));
        rst_n          = 1'b0;
        tag_rreq_ready = 1'b0;
        tag_rreq_chnl  = '0;
        tag_rreq_sz    = '0;
        tag_rreq_last  = 1'b0;
        tag_rreq_misc  = '0;
        tag_rrsp_ready = '0;
        req_table = '{
            28'h2_0_010_11, 28'h0_1_004_22, 28'h3_0_3ff_33, 28'h1_1_080_44,
            28'h0_0_020_55, 28'h2_1_001_66, 28'h1_0_100_77, 28'h3_1_200_88,
            28'h0_1_040_99, 28'h2_0_0c0_aa, 28'h1_1_155_bb, 28'h3_0_2aa_cc,
            28'h1_0_007_dd, 28'h0_0_333_ee, 28'h2_1_0f0_ff, 28'h3_1_012_01,
            28'h3_0_00f_02, 28'h0_1_111_03, 28'h2_0_222_04, 28'h1_1_0ab_05,
            28'h0_0_3c3_06, 28'h3_1_050_07, 28'h2_1_099_08, 28'h1_0_1fe_09
        };
        for (int t = 0; t < np_tag_pkg::TAG_NUM; t++) begin
            free_model.push_back(np_tag_pkg::TAG_NUM_LOG'(t));  // fill counts up from 0
        end
        repeat (2) @(posedge dma_clk);
        rst_n <= 1'b1;

        waited = 0;
        @(negedge dma_clk);
        while (!init_done) begin
            waited++;
            if (waited > np_tag_pkg::TAG_NUM + 2) report_timeout("init_done did not rise");
            @(negedge dma_clk);
        end
        assert (waited >= np_tag_pkg::TAG_NUM)
            else report_mismatch("init_done", 0, init_done);  // fill takes TAG_NUM writes

        for (int r = 0; r < 16; r++) alloc_row(r);  // drains the pool
        @(negedge dma_clk);
        assert (tag_rreq_valid == 1'b0) else report_mismatch("tag_rreq_valid", 0, tag_rreq_valid);
        repeat (8) release_oldest();
        for (int r = 16; r < 24; r++) alloc_row(r);  // reissues released tags
        while (outstanding.size() != 0) release_oldest();
        repeat (2) @(negedge dma_clk);

        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire
